// ==== all.f ====
common/iob_wb_pkg.sv
iob2wishbone/iob2wishbone.sv
wb_ram/wb_ram.sv
rtl/wb_decoder.sv
rtl/iob_wb_top.sv
test/iob_wb_tb.sv

// ==== Makefile ====
# Verilator simulation of the IOb to Wishbone bridge

TOP       ?= iob_wb_tb
SEED      ?= 1
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f

VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/iob_wb_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module iob_wb_tb;
   import iob_wb_pkg::*;

   localparam int SEL_BIT   = 10;
   localparam int RAM0_WAIT = 0;
   localparam int RAM1_WAIT = 3;
   localparam int N_WORDS   = 64;
   localparam int N_RANDOM  = 300;
   localparam int TIMEOUT   = 50;

   logic      clk;
   logic      rst;
   logic      cke;
   iob_req_t  iob_req;
   iob_resp_t iob_resp;

   logic [DATA_W-1:0] model_mem [int];   // Expected word per byte address
   integer            seed;
   string             test_name;

   iob_wb_top #(
      .READ_BYTES(4),
      .DEPTH_W   (8),
      .SEL_BIT   (SEL_BIT),
      .RAM0_WAIT (RAM0_WAIT),
      .RAM1_WAIT (RAM1_WAIT)
   ) UUT (
      .clk_i     (clk),
      .cke_i     (cke),
      .rst_i     (rst),
      .iob_req_i (iob_req),
      .iob_resp_o(iob_resp)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
         else stop_run($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                 test_name, what, exp, act));
   endtask

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_word;
      for (int i = 0; i < STRB_W; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return res;
   endfunction

   function automatic logic [ADDR_W-1:0] bank_addr(input int bank, input int word);
      return (ADDR_W'(bank) << SEL_BIT) | (ADDR_W'(word) << 2);
   endfunction

   // One IOb request, optionally with a cke_i low stretch while it is outstanding
   task automatic do_request(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [STRB_W-1:0] wstrb, input bit stall);
      int                wait_cnt;
      int                lat;
      int                exp_lat;
      int                stall_start;
      int                stall_len;
      bit                done;
      bit                stalled;
      logic [DATA_W-1:0] exp_word;

      exp_lat     = (addr[SEL_BIT] ? RAM1_WAIT : RAM0_WAIT) + 2;
      stall_start = 1 + ($unsigned($random(seed)) % 3);
      stall_len   = stall ? ($unsigned($random(seed)) % 8) : 0;
      if (wstrb == '0) begin
         exp_word = model_mem[addr];
      end else begin
         model_mem[addr] = merge_bytes(model_mem[addr], wdata, wstrb);
      end

      wait_cnt = 0;
      @(negedge clk);
      while (iob_resp.ready !== 1'b1) begin
         wait_cnt++;
         if (wait_cnt >= TIMEOUT) begin
            stop_run("Timeout waiting for ready before a new request");
         end
         @(negedge clk);
      end
      iob_req.avalid = 1'b1;
      iob_req.addr   = addr;
      iob_req.wdata  = wdata;
      iob_req.wstrb  = wstrb;

      lat     = 0;
      done    = 1'b0;
      stalled = 1'b0;
      while (!done) begin
         @(negedge clk);
         iob_req.avalid = 1'b0;
         lat++;
         cke = !(lat >= stall_start && lat < stall_start + stall_len);
         if (!cke) begin
            stalled = 1'b1;
         end
         #1;
         if (!cke) begin
            assert (iob_resp.rvalid === 1'b0 && iob_resp.ready === 1'b0)
               else stop_run("Response seen while cke was low");
         end else begin
            if (!stalled) begin
               // Exact timing holds until the first cke low cycle
               check_value("ready", lat == exp_lat, iob_resp.ready);
               check_value("rvalid", wstrb == '0 && lat == exp_lat, iob_resp.rvalid);
            end else if (wstrb != '0) begin
               assert (iob_resp.rvalid !== 1'b1)
                  else stop_run("rvalid produced by a write");
            end
            done = (wstrb == '0) ? iob_resp.rvalid : iob_resp.ready;
         end
         if (!done && lat >= TIMEOUT) begin
            stop_run("Timeout waiting for the response of a request");
         end
      end

      if (wstrb == '0) begin
         check_value("read data", exp_word, iob_resp.rdata);
      end
      if (stalled) begin
         assert (lat >= exp_lat)
            else stop_run("Stalled request finished faster than the bank latency");
      end
   endtask

   initial begin
      int          bank;
      int          word;
      logic [31:0] rnd;
      logic [3:0]  strb;

      seed      = 32'h7717;
      rst       = 1'b1;
      cke       = 1'b1;
      iob_req   = '0;
      test_name = "reset";
      repeat (16) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      #1;
      check_value("rvalid", 1'b0, iob_resp.rvalid);
      check_value("ready", 1'b1, iob_resp.ready);

      test_name = "fill";                   // Full-word writes, both banks
      for (bank = 0; bank < 2; bank++) begin
         for (word = 0; word < N_WORDS; word++) begin
            do_request(bank_addr(bank, word), $random(seed), 4'hF, 1'b0);
         end
      end

      test_name = "readback";
      for (bank = 0; bank < 2; bank++) begin
         for (word = 0; word < N_WORDS; word++) begin
            do_request(bank_addr(bank, word), '0, 4'h0, 1'b0);
         end
      end

      test_name = "random";
      for (int n = 0; n < N_RANDOM; n++) begin
         rnd  = $random(seed);
         bank = rnd[0];
         word = $unsigned($random(seed)) % N_WORDS;
         strb = rnd[5:2];
         if (rnd[1] && strb == 4'h0) begin
            strb = 4'h1;                    // A write needs a strobe
         end else if (!rnd[1]) begin
            strb = 4'h0;
         end
         do_request(bank_addr(bank, word), $random(seed), strb, rnd[7:6] == 2'b00);
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rtl/iob_wb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module iob_wb_top #(
   parameter int READ_BYTES = 4,
   parameter int DEPTH_W    = 8,
   parameter int SEL_BIT    = 10,
   parameter int RAM0_WAIT  = 0,
   parameter int RAM1_WAIT  = 3
) (
   input  logic                  clk_i,
   input  logic                  cke_i,
   input  logic                  rst_i,
   input  iob_wb_pkg::iob_req_t  iob_req_i,
   output iob_wb_pkg::iob_resp_t iob_resp_o
);
   import iob_wb_pkg::*;

   wb_req_t  wb_req;
   wb_resp_t wb_resp;
   wb_req_t  wb_req0;
   wb_resp_t wb_resp0;
   wb_req_t  wb_req1;
   wb_resp_t wb_resp1;

   iob2wishbone #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .READ_BYTES(READ_BYTES)
   ) bridge (
      .clk_i     (clk_i),
      .cke_i     (cke_i),
      .rst_i     (rst_i),
      .iob_req_i (iob_req_i),
      .iob_resp_o(iob_resp_o),
      .wb_req_o  (wb_req),
      .wb_resp_i (wb_resp)
   );

   wb_decoder #(
      .SEL_BIT(SEL_BIT)
   ) decoder (
      .wb_req_i  (wb_req),
      .wb_resp_o (wb_resp),
      .wb_req0_o (wb_req0),
      .wb_req1_o (wb_req1),
      .wb_resp0_i(wb_resp0),
      .wb_resp1_i(wb_resp1)
   );

   wb_ram #(.DATA_W(DATA_W), .DEPTH_W(DEPTH_W), .WAIT_CYCLES(RAM0_WAIT)) ram0 (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_req_i (wb_req0),
      .wb_resp_o(wb_resp0)
   );

   wb_ram #(.DATA_W(DATA_W), .DEPTH_W(DEPTH_W), .WAIT_CYCLES(RAM1_WAIT)) ram1 (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_req_i (wb_req1),
      .wb_resp_o(wb_resp1)
   );

endmodule

`default_nettype wire

// ==== rtl/wb_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_decoder #(
   parameter int SEL_BIT = 10
) (
   input  iob_wb_pkg::wb_req_t  wb_req_i,
   output iob_wb_pkg::wb_resp_t wb_resp_o,
   output iob_wb_pkg::wb_req_t  wb_req0_o,
   output iob_wb_pkg::wb_req_t  wb_req1_o,
   input  iob_wb_pkg::wb_resp_t wb_resp0_i,
   input  iob_wb_pkg::wb_resp_t wb_resp1_i
);

   logic hit1;

   assign hit1 = wb_req_i.addr[SEL_BIT];   // Bank select

   always_comb begin
      wb_req0_o     = wb_req_i;
      wb_req0_o.cyc = wb_req_i.cyc & ~hit1;
      wb_req0_o.stb = wb_req_i.stb & ~hit1;
      wb_req1_o     = wb_req_i;
      wb_req1_o.cyc = wb_req_i.cyc & hit1;
      wb_req1_o.stb = wb_req_i.stb & hit1;
   end

   // Address is held until ack, so the select still points at the acking slave
   always_comb begin
      if (hit1) begin
         wb_resp_o = wb_resp1_i;
      end else begin
         wb_resp_o = wb_resp0_i;
      end
   end

   always_comb begin
      a_one_ack : assert (!(wb_resp0_i.ack === 1'b1 && wb_resp1_i.ack === 1'b1))
         else $error("Both slaves acknowledged");
   end

endmodule

`default_nettype wire

// ==== wb_ram/wb_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_ram #(
   parameter int DATA_W      = iob_wb_pkg::DATA_W,
   parameter int DEPTH_W     = 8,
   parameter int WAIT_CYCLES = 0
) (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  iob_wb_pkg::wb_req_t  wb_req_i,
   output iob_wb_pkg::wb_resp_t wb_resp_o
);

   localparam int STRB_W = DATA_W / 8;
   localparam int CNT_W  = $clog2(WAIT_CYCLES + 2);

   logic [DATA_W-1:0]  mem [2**DEPTH_W];
   logic [CNT_W-1:0]   cnt_q;
   logic               ack_q;
   logic [DATA_W-1:0]  rdata_q;
   logic [DEPTH_W-1:0] word_addr;
   logic               req;
   logic               done;

   assign word_addr = wb_req_i.addr[DEPTH_W+1:2];   // Word index
   assign req       = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
   assign done      = req & (cnt_q == CNT_W'(WAIT_CYCLES));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q <= '0;
         ack_q <= 1'b0;
      end else begin
         ack_q <= done;                             // One cycle only
         if (done || !req) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (done) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (wb_req_i.we && wb_req_i.sel[i]) begin
               mem[word_addr][8*i +: 8] <= wb_req_i.data[8*i +: 8];
            end
         end
         rdata_q <= mem[word_addr];
      end
   end

   always_comb begin
      wb_resp_o.ack  = ack_q;
      wb_resp_o.data = rdata_q;
   end

   // Master holds the strobe through the ack cycle
   a_ack_in_cycle : assert property (@(posedge clk_i) disable iff (rst_i)
      ack_q |-> (wb_req_i.stb && wb_req_i.cyc))
      else $error("ack outside a bus cycle");

endmodule

`default_nettype wire

// ==== iob2wishbone/iob2wishbone.sv ====
`timescale 1ns/1ns
`default_nettype none

module iob2wishbone #(
   parameter int ADDR_W     = iob_wb_pkg::ADDR_W,
   parameter int DATA_W     = iob_wb_pkg::DATA_W,
   parameter int READ_BYTES = 4
) (
   input  logic                  clk_i,
   input  logic                  cke_i,
   input  logic                  rst_i,
   input  iob_wb_pkg::iob_req_t  iob_req_i,
   output iob_wb_pkg::iob_resp_t iob_resp_o,
   output iob_wb_pkg::wb_req_t   wb_req_o,
   input  iob_wb_pkg::wb_resp_t  wb_resp_i
);

   localparam int STRB_W = DATA_W / 8;
   localparam logic [STRB_W-1:0] RB_MASK = STRB_W'((1 << READ_BYTES) - 1);

   logic              avalid_q;   // Request outstanding
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic [STRB_W-1:0] sel_q;
   logic              we_q;
   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;
   logic              we;
   logic [STRB_W-1:0] sel;

   assign we  = |iob_req_i.wstrb;
   assign sel = we ? iob_req_i.wstrb : RB_MASK << iob_req_i.addr[1:0];

   // Live request on acceptance, held copy afterwards
   always_comb begin
      wb_req_o.stb = iob_req_i.avalid | avalid_q;
      wb_req_o.cyc = wb_req_o.stb;
      if (iob_req_i.avalid) begin
         wb_req_o.we   = we;
         wb_req_o.sel  = sel;
         wb_req_o.addr = iob_req_i.addr;
         wb_req_o.data = iob_req_i.wdata;
      end else begin
         wb_req_o.we   = we_q;
         wb_req_o.sel  = sel_q;
         wb_req_o.addr = addr_q;
         wb_req_o.data = wdata_q;
      end
   end

   always_comb begin
      iob_resp_o.rvalid = cke_i & ack_q & ~we_q;     // Reads only
      iob_resp_o.rdata  = rdata_q;
      iob_resp_o.ready  = cke_i & (~avalid_q | ack_q);
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         avalid_q <= 1'b0;
         ack_q    <= 1'b0;
      end else if (cke_i) begin
         if (iob_req_i.avalid | wb_resp_i.ack) begin
            avalid_q <= iob_req_i.avalid;            // Set on accept, clear on ack
         end
         ack_q <= wb_resp_i.ack;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cke_i) begin
         if (iob_req_i.avalid) begin
            addr_q  <= iob_req_i.addr;
            wdata_q <= iob_req_i.wdata;
            sel_q   <= sel;
            we_q    <= we;
         end
         if (wb_resp_i.ack) begin
            rdata_q <= wb_resp_i.data;
         end
      end
   end

   a_ack_has_req : assert property (@(posedge clk_i) disable iff (rst_i)
      wb_resp_i.ack |-> (avalid_q | iob_req_i.avalid))
      else $error("Wishbone ack without a request");

   // Master must wait for ready before raising avalid
   a_avalid_ready : assert property (@(posedge clk_i) disable iff (rst_i)
      iob_req_i.avalid |-> iob_resp_o.ready)
      else $error("avalid while ready low");

endmodule

`default_nettype wire

// ==== common/iob_wb_pkg.sv ====
`default_nettype none

package iob_wb_pkg;

   localparam int ADDR_W = 32;           // Byte address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // IOb native request, a write has a nonzero wstrb
   typedef struct packed {
      logic              avalid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } iob_req_t;

   typedef struct packed {
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic              ready;
   } iob_resp_t;

   // Wishbone classic, master side
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [STRB_W-1:0] sel;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } wb_req_t;

   // Wishbone classic, slave side
   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] data;
   } wb_resp_t;

endpackage

`default_nettype wire
